// ==== rs_branch_defines.svh ====
`ifndef RS_BRANCH_DEFINES_SVH
`define RS_BRANCH_DEFINES_SVH

// Station geometry
`define RS_ENT_NUM    4
`define RS_ENT_SEL    2

`define DATA_LEN      32
`define ADDR_LEN      32
`define RRF_SEL       6   // Rename register tag
`define SPECTAG_LEN   5   // One-hot branch tag
`define ALU_OP_WIDTH  4
`define OPCODE_LEN    7

// Result buses watched for wakeup
`define EX_PORTS      2

`endif

// ==== rs_branch_pkg.sv ====
`include "rs_branch_defines.svh"

package rs_branch_pkg;

  typedef logic [`DATA_LEN-1:0]     data_t;
  typedef logic [`ADDR_LEN-1:0]     addr_t;
  typedef logic [`RRF_SEL-1:0]      rrf_tag_t;
  typedef logic [`SPECTAG_LEN-1:0]  spectag_t;
  typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;
  typedef logic [`OPCODE_LEN-1:0]   opcode_t;

  typedef logic [`RS_ENT_SEL-1:0]   ent_sel_t;
  typedef logic [`RS_ENT_NUM-1:0]   ent_vec_t;  // One bit per entry

  // Everything a branch carries besides its operands
  typedef struct packed {
    addr_t    pc;
    data_t    imm;
    rrf_tag_t rrftag;
    logic     dstval;    // Writes a link register
    alu_op_t  alu_op;
    spectag_t spectag;
    opcode_t  opcode;
  } br_payload_t;

  // One execution result bus
  typedef struct packed {
    data_t    data;
    rrf_tag_t dst;
    logic     kill;      // Result is squashed, no wakeup
  } ex_result_t;

endpackage

// ==== rs_slot_if.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

interface rs_slot_if;
  import rs_branch_pkg::*;

  ent_vec_t    valid1;                  // Registered operand valid bits
  ent_vec_t    valid2;
  data_t       fwd_src1 [`RS_ENT_NUM];  // Operands with this cycle's wakeup applied
  data_t       fwd_src2 [`RS_ENT_NUM];
  br_payload_t payload  [`RS_ENT_NUM];

  modport slots (
    output valid1, valid2, fwd_src1, fwd_src2, payload
  );

  modport select (
    input valid1, valid2, fwd_src1, fwd_src2, payload
  );

  // Tracker only looks at the spectags
  modport track (
    input payload
  );

endinterface

// ==== rs_branch_slots.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module rs_branch_slots (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     we1,
  input  logic                     we2,
  input  rs_branch_pkg::ent_sel_t    waddr1,
  input  rs_branch_pkg::ent_sel_t    waddr2,
  input  rs_branch_pkg::br_payload_t wpayload_1,
  input  rs_branch_pkg::br_payload_t wpayload_2,
  input  rs_branch_pkg::data_t       wsrc1_1,
  input  rs_branch_pkg::data_t       wsrc2_1,
  input  rs_branch_pkg::data_t       wsrc1_2,
  input  rs_branch_pkg::data_t       wsrc2_2,
  input  logic                     wvalid1_1,
  input  logic                     wvalid2_1,
  input  logic                     wvalid1_2,
  input  logic                     wvalid2_2,
  input  rs_branch_pkg::ex_result_t  ex_bus [`EX_PORTS],
  rs_slot_if.slots                 slot
);
  import rs_branch_pkg::*;

  br_payload_t payload  [`RS_ENT_NUM];
  data_t       src1     [`RS_ENT_NUM];  // Value, or rename tag while not valid
  data_t       src2     [`RS_ENT_NUM];
  ent_vec_t    valid1;
  ent_vec_t    valid2;

  data_t       nxt_src1 [`RS_ENT_NUM];
  data_t       nxt_src2 [`RS_ENT_NUM];
  ent_vec_t    nxt_valid1;
  ent_vec_t    nxt_valid2;

  ent_vec_t    wr1;  // Per-entry write strobes
  ent_vec_t    wr2;

  // Returns {resolved, value}
  function automatic logic [`DATA_LEN:0] wake(input data_t opr, input logic rdy,
                                              input ex_result_t bus [`EX_PORTS]);
    logic [`DATA_LEN:0] res;
    res = {rdy, opr};
    if (!rdy) begin
      // Walk downwards so the lowest matching bus is the last to land
      for (int b = `EX_PORTS - 1; b >= 0; b--) begin
        if (!bus[b].kill && opr[`RRF_SEL-1:0] == bus[b].dst) begin
          res = {1'b1, bus[b].data};
        end
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < `RS_ENT_NUM; i++) begin
      wr1[i] = we1 && (waddr1 == ent_sel_t'(i));
      wr2[i] = we2 && (waddr2 == ent_sel_t'(i)) && !wr1[i];  // Port 1 wins a clash
    end
  end

  always_comb begin
    for (int i = 0; i < `RS_ENT_NUM; i++) begin
      {nxt_valid1[i], nxt_src1[i]} = wake(src1[i], valid1[i], ex_bus);
      {nxt_valid2[i], nxt_src2[i]} = wake(src2[i], valid2[i], ex_bus);
    end
  end

  // Operand and payload storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < `RS_ENT_NUM; i++) begin
      if (wr1[i]) begin
        payload[i] <= wpayload_1;
        src1[i]    <= wsrc1_1;
        src2[i]    <= wsrc2_1;
      end else if (wr2[i]) begin
        payload[i] <= wpayload_2;
        src1[i]    <= wsrc1_2;
        src2[i]    <= wsrc2_2;
      end else begin
        src1[i] <= nxt_src1[i];  // Keep woken values
        src2[i] <= nxt_src2[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid1 <= '0;
      valid2 <= '0;
    end else begin
      for (int i = 0; i < `RS_ENT_NUM; i++) begin
        if (wr1[i]) begin
          valid1[i] <= wvalid1_1;
          valid2[i] <= wvalid2_1;
        end else if (wr2[i]) begin
          valid1[i] <= wvalid1_2;
          valid2[i] <= wvalid2_2;
        end else begin
          valid1[i] <= nxt_valid1[i];
          valid2[i] <= nxt_valid2[i];
        end
      end
    end
  end

  assign slot.valid1   = valid1;
  assign slot.valid2   = valid2;
  assign slot.fwd_src1 = nxt_src1;  // Same-cycle forwarding
  assign slot.fwd_src2 = nxt_src2;
  assign slot.payload  = payload;

endmodule

// ==== rs_branch_tracker.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module rs_branch_tracker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   we1,
  input  logic                   we2,
  input  rs_branch_pkg::ent_sel_t  waddr1,
  input  rs_branch_pkg::ent_sel_t  waddr2,
  input  rs_branch_pkg::ent_sel_t  issue_addr,
  input  logic                   wspecbit_1,
  input  logic                   wspecbit_2,
  input  logic                   clear_busy,
  input  logic                   prmiss,
  input  logic                   prsuccess,
  input  rs_branch_pkg::spectag_t  prtag,
  input  rs_branch_pkg::spectag_t  specfixtag,
  rs_slot_if.track               slot,
  output rs_branch_pkg::ent_vec_t  busyvec,
  output rs_branch_pkg::ent_vec_t  prbusyvec_next,
  output rs_branch_pkg::ent_vec_t  spec_live
);
  import rs_branch_pkg::*;

  ent_vec_t specbitvec;
  ent_vec_t survive_miss;   // Entry not on the mispredicted path
  ent_vec_t keep_spec;      // Entry not resolved by this success
  ent_vec_t spec_success;

  always_comb begin
    for (int i = 0; i < `RS_ENT_NUM; i++) begin
      survive_miss[i] = (slot.payload[i].spectag & specfixtag) == '0;
      keep_spec[i]    = slot.payload[i].spectag != prtag;
    end
  end

  assign spec_success   = specbitvec & keep_spec;
  assign prbusyvec_next = busyvec & survive_miss;
  assign spec_live      = prsuccess ? spec_success : specbitvec;

  always_ff @(posedge clk) begin
    if (reset) begin
      busyvec    <= '0;
      specbitvec <= '0;
    end else if (prmiss) begin
      busyvec    <= prbusyvec_next;
      specbitvec <= '0;
    end else if (prsuccess) begin
      specbitvec <= spec_success;  // No allocation in this cycle
      if (clear_busy) begin
        busyvec[issue_addr] <= 1'b0;
      end
    end else begin
      // Port 2 first so port 1 overrides on a shared entry
      if (we2) begin
        busyvec[waddr2]    <= 1'b1;
        specbitvec[waddr2] <= wspecbit_2;
      end
      if (we1) begin
        busyvec[waddr1]    <= 1'b1;
        specbitvec[waddr1] <= wspecbit_1;
      end
      if (clear_busy) begin
        busyvec[issue_addr] <= 1'b0;
      end
    end
  end

endmodule

// ==== rs_branch_select.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module rs_branch_select (
  input  rs_branch_pkg::ent_sel_t    issue_addr,
  input  rs_branch_pkg::ent_vec_t    busyvec,
  input  rs_branch_pkg::ent_vec_t    spec_live,
  rs_slot_if.select                slot,
  output rs_branch_pkg::ent_vec_t    ready,
  output rs_branch_pkg::data_t       ex_src1,
  output rs_branch_pkg::data_t       ex_src2,
  output rs_branch_pkg::br_payload_t payload,
  output logic                     specbit
);

  // Entry can issue once both operands are in
  always_comb begin
    for (int i = 0; i < `RS_ENT_NUM; i++) begin
      ready[i] = busyvec[i] & slot.valid1[i] & slot.valid2[i];
    end
  end

  // Read port for the entry picked by the issue logic
  assign ex_src1 = slot.fwd_src1[issue_addr];
  assign ex_src2 = slot.fwd_src2[issue_addr];
  assign payload = slot.payload[issue_addr];
  assign specbit = spec_live[issue_addr];  // Already reflects prsuccess

endmodule

// ==== rs_branch.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module rs_branch (
  input  logic                     clk,
  input  logic                     reset,
  // Branch prediction events
  input  logic                     prmiss,
  input  logic                     prsuccess,
  input  rs_branch_pkg::spectag_t    prtag,
  input  rs_branch_pkg::spectag_t    specfixtag,
  output rs_branch_pkg::ent_vec_t    busyvec,
  output rs_branch_pkg::ent_vec_t    prbusyvec_next,
  // Issue
  input  logic                     clear_busy,
  input  rs_branch_pkg::ent_sel_t    issue_addr,
  output rs_branch_pkg::ent_vec_t    ready,
  output rs_branch_pkg::data_t       ex_src1,
  output rs_branch_pkg::data_t       ex_src2,
  output rs_branch_pkg::br_payload_t payload,
  output logic                     specbit,
  // Dispatch port 1
  input  logic                     we1,
  input  rs_branch_pkg::ent_sel_t    waddr1,
  input  rs_branch_pkg::br_payload_t wpayload_1,
  input  rs_branch_pkg::data_t       wsrc1_1,
  input  rs_branch_pkg::data_t       wsrc2_1,
  input  logic                     wvalid1_1,
  input  logic                     wvalid2_1,
  input  logic                     wspecbit_1,
  // Dispatch port 2
  input  logic                     we2,
  input  rs_branch_pkg::ent_sel_t    waddr2,
  input  rs_branch_pkg::br_payload_t wpayload_2,
  input  rs_branch_pkg::data_t       wsrc1_2,
  input  rs_branch_pkg::data_t       wsrc2_2,
  input  logic                     wvalid1_2,
  input  logic                     wvalid2_2,
  input  logic                     wspecbit_2,
  // Result buses
  input  rs_branch_pkg::data_t       exrslt [`EX_PORTS],
  input  rs_branch_pkg::rrf_tag_t    exdst  [`EX_PORTS],
  input  logic [`EX_PORTS-1:0]     kill_spec
);
  import rs_branch_pkg::*;

  ex_result_t ex_bus [`EX_PORTS];
  ent_vec_t   spec_live;

  rs_slot_if slot_bus ();

  always_comb begin
    for (int b = 0; b < `EX_PORTS; b++) begin
      ex_bus[b] = '{data: exrslt[b], dst: exdst[b], kill: kill_spec[b]};
    end
  end

  rs_branch_slots u_slots (
    .clk        (clk),
    .reset      (reset),
    .we1        (we1),
    .we2        (we2),
    .waddr1     (waddr1),
    .waddr2     (waddr2),
    .wpayload_1 (wpayload_1),
    .wpayload_2 (wpayload_2),
    .wsrc1_1    (wsrc1_1),
    .wsrc2_1    (wsrc2_1),
    .wsrc1_2    (wsrc1_2),
    .wsrc2_2    (wsrc2_2),
    .wvalid1_1  (wvalid1_1),
    .wvalid2_1  (wvalid2_1),
    .wvalid1_2  (wvalid1_2),
    .wvalid2_2  (wvalid2_2),
    .ex_bus     (ex_bus),
    .slot       (slot_bus.slots)
  );

  rs_branch_tracker u_tracker (
    .clk            (clk),
    .reset          (reset),
    .we1            (we1),
    .we2            (we2),
    .waddr1         (waddr1),
    .waddr2         (waddr2),
    .issue_addr     (issue_addr),
    .wspecbit_1     (wspecbit_1),
    .wspecbit_2     (wspecbit_2),
    .clear_busy     (clear_busy),
    .prmiss         (prmiss),
    .prsuccess      (prsuccess),
    .prtag          (prtag),
    .specfixtag     (specfixtag),
    .slot           (slot_bus.track),
    .busyvec        (busyvec),
    .prbusyvec_next (prbusyvec_next),
    .spec_live      (spec_live)
  );

  rs_branch_select u_select (
    .issue_addr (issue_addr),
    .busyvec    (busyvec),
    .spec_live  (spec_live),
    .slot       (slot_bus.select),
    .ready      (ready),
    .ex_src1    (ex_src1),
    .ex_src2    (ex_src2),
    .payload    (payload),
    .specbit    (specbit)
  );

endmodule

// ==== rs_branch_checker.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module rs_branch_checker (
  input logic                    clk,
  input logic                    reset,
  input logic                    prmiss,
  input logic                    clear_busy,
  input logic                    we1,
  input logic                    we2,
  input rs_branch_pkg::ent_sel_t waddr1,
  input rs_branch_pkg::ent_sel_t waddr2,
  input rs_branch_pkg::ent_sel_t issue_addr,
  input rs_branch_pkg::ent_vec_t busyvec,
  input rs_branch_pkg::ent_vec_t prbusyvec_next,
  input rs_branch_pkg::ent_vec_t ready
);
  import rs_branch_pkg::*;

  int   fail_count = 0;
  logic clear_only;  // Issued entry freed, nothing lands on it

  assign clear_only = clear_busy && !prmiss
                      && !(we1 && waddr1 == issue_addr)
                      && !(we2 && waddr2 == issue_addr);

  a_reset_empty: assert property (@(posedge clk) reset |=> busyvec == '0)
    else begin
      fail_count++;
      $error("busyvec not empty after reset");
    end

  a_ready_busy: assert property (@(posedge clk) disable iff (reset) (ready & ~busyvec) == '0)
    else begin
      fail_count++;
      $error("ready set on an entry that is not busy");
    end

  // Misprediction flush follows the predicted vector
  a_prmiss_flush: assert property (@(posedge clk) disable iff (reset)
                                   prmiss |=> busyvec == $past(prbusyvec_next))
    else begin
      fail_count++;
      $error("busyvec after prmiss differs from prbusyvec_next");
    end

  a_clear_frees: assert property (@(posedge clk) disable iff (reset)
                                  clear_only |=> !busyvec[$past(issue_addr)])
    else begin
      fail_count++;
      $error("entry still busy after clear_busy");
    end

endmodule

bind rs_branch rs_branch_checker u_checker (
  .clk            (clk),
  .reset          (reset),
  .prmiss         (prmiss),
  .clear_busy     (clear_busy),
  .we1            (we1),
  .we2            (we2),
  .waddr1         (waddr1),
  .waddr2         (waddr2),
  .issue_addr     (issue_addr),
  .busyvec        (busyvec),
  .prbusyvec_next (prbusyvec_next),
  .ready          (ready)
);

// ==== tb_rs_branch.sv ====
`timescale 1ns/1ps
`include "rs_branch_defines.svh"

module tb_rs_branch;
  import rs_branch_pkg::*;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        prmiss = 1'b0, prsuccess = 1'b0, clear_busy = 1'b0, we1 = 1'b0, we2 = 1'b0;
  logic        wvalid1_1 = 1'b0, wvalid2_1 = 1'b0, wspecbit_1 = 1'b0;
  logic        wvalid1_2 = 1'b0, wvalid2_2 = 1'b0, wspecbit_2 = 1'b0;
  logic [`EX_PORTS-1:0] kill_spec = '1;  // Idle buses carry killed results
  spectag_t    prtag = '0, specfixtag = '0;
  ent_sel_t    issue_addr = '0, waddr1 = '0, waddr2 = '0;
  br_payload_t wpayload_1 = '0, wpayload_2 = '0;
  data_t       wsrc1_1 = '0, wsrc2_1 = '0, wsrc1_2 = '0, wsrc2_2 = '0;
  data_t       exrslt [`EX_PORTS] = '{default: '0};
  rrf_tag_t    exdst  [`EX_PORTS] = '{default: '0};
  logic        specbit;
  ent_vec_t    busyvec, prbusyvec_next, ready;
  br_payload_t payload;
  data_t       ex_src1, ex_src2;
  integer      seed = 21378;

  rs_branch UUT (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  // Stop at the first assertion the bound checker flags
  always @(negedge clk) begin
    if (UUT.u_checker.fail_count != 0) begin
      $display("Assertion checker flagged a failure");
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failure");
    end
  end

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "operand mismatch");
    end
  endtask

  task automatic check_payload(input br_payload_t got, input br_payload_t exp,
                               input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "payload mismatch");
    end
  endtask

  task automatic check_vec(input ent_vec_t got, input ent_vec_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "entry vector mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "specbit mismatch");
    end
  endtask

  // Polls busy or ready of one entry on falling edges
  task automatic wait_entry(input int idx, input bit on_busy, input logic level);
    int n;
    n = 0;
    @(negedge clk);
    while ((on_busy ? busyvec[idx] : ready[idx]) !== level) begin
      if (n == 8) begin
        $display("Timeout: %s bit of entry %0d never went to %b",
                 on_busy ? "busy" : "ready", idx, level);
        $display("*** TEST FAILED ***");
        $fatal(1, "wait timeout");
      end else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  function automatic br_payload_t new_payload(input spectag_t tag);
    br_payload_t pl;
    pl.pc      = $random(seed);
    pl.imm     = $random(seed);
    pl.rrftag  = rrf_tag_t'($random(seed));
    pl.dstval  = 1'b1;
    pl.alu_op  = alu_op_t'($random(seed));
    pl.spectag = tag;
    pl.opcode  = 7'b1100011;  // BRANCH major opcode
    return pl;
  endfunction

  // Source 1 is always valid here
  task automatic load_port(input int port, input ent_sel_t idx, input br_payload_t pl,
                           input data_t s1, input data_t s2, input logic v2, input logic sp);
    if (port == 1) begin
      we1        <= 1'b1;
      waddr1     <= idx;
      wpayload_1 <= pl;
      wsrc1_1    <= s1;
      wsrc2_1    <= s2;
      wvalid1_1  <= 1'b1;
      wvalid2_1  <= v2;
      wspecbit_1 <= sp;
    end else begin
      we2        <= 1'b1;
      waddr2     <= idx;
      wpayload_2 <= pl;
      wsrc1_2    <= s1;
      wsrc2_2    <= s2;
      wvalid1_2  <= 1'b1;
      wvalid2_2  <= v2;
      wspecbit_2 <= sp;
    end
  endtask

  task automatic idle_edge;
    @(posedge clk);
    we1        <= 1'b0;
    we2        <= 1'b0;
    clear_busy <= 1'b0;
    prmiss     <= 1'b0;
    prsuccess  <= 1'b0;
  endtask

  task automatic show_entry(input ent_sel_t idx);
    @(posedge clk);
    issue_addr <= idx;
    @(negedge clk);
  endtask

  task automatic clear_entry(input ent_sel_t idx);
    @(posedge clk);
    issue_addr <= idx;
    clear_busy <= 1'b1;
    idle_edge();
    wait_entry(idx, 1'b1, 1'b0);
  endtask

  // All four entries, operands valid, speculative
  task automatic fill_entries(input spectag_t tags [4]);
    for (int i = 0; i < 4; i += 2) begin
      @(posedge clk);
      load_port(1, ent_sel_t'(i), new_payload(tags[i]), $random(seed), $random(seed),
                1'b1, 1'b1);
      load_port(2, ent_sel_t'(i + 1), new_payload(tags[i + 1]), $random(seed),
                $random(seed), 1'b1, 1'b1);
    end
    idle_edge();
    wait_entry(3, 1'b1, 1'b1);
  endtask

  task automatic test_single_issue;
    br_payload_t pl;
    data_t       a, b;
    pl = new_payload(5'b00001);
    a  = $random(seed);
    b  = $random(seed);
    @(posedge clk);
    load_port(1, 2'd0, pl, a, b, 1'b1, 1'b0);
    idle_edge();
    wait_entry(0, 1'b0, 1'b1);
    check_vec(busyvec, 4'b0001, "busyvec after dispatch");
    show_entry(2'd0);
    check_data(ex_src1, a, "ex_src1");
    check_data(ex_src2, b, "ex_src2");
    check_payload(payload, pl, "payload");
    clear_entry(2'd0);
    check_vec(ready, 4'b0000, "ready after clear");
  endtask

  task automatic test_wakeup;
    br_payload_t pl;
    data_t       a, tagword, res, res2;
    pl      = new_payload(5'b00010);
    a       = $random(seed);
    res     = $random(seed);
    res2    = ~res;
    tagword = $random(seed);
    tagword[`RRF_SEL-1:0] = 6'h15;  // Upper bits are don't care
    @(posedge clk);
    load_port(1, 2'd1, pl, a, tagword, 1'b0, 1'b0);
    idle_edge();
    issue_addr <= 2'd1;
    // Foreign tag on bus 0, killed match on bus 1
    exdst[0]   <= 6'h16;
    exrslt[0]  <= res;
    exdst[1]   <= 6'h15;
    exrslt[1]  <= res2;
    kill_spec  <= 2'b10;
    @(negedge clk);
    check_vec(busyvec, 4'b0010, "busyvec with pending operand");
    check_vec(ready, 4'b0000, "ready with pending operand");
    check_data(ex_src2, tagword, "ex_src2 before wakeup");
    @(posedge clk);
    exdst[0]  <= 6'h15;  // Both buses match now, bus 0 has priority
    kill_spec <= 2'b00;
    @(negedge clk);
    check_data(ex_src2, res, "ex_src2 forwarded");
    check_vec(ready, 4'b0000, "ready in wakeup cycle");
    @(posedge clk);
    kill_spec <= 2'b11;
    wait_entry(1, 1'b0, 1'b1);
    check_data(ex_src2, res, "ex_src2 after wakeup");
    clear_entry(2'd1);
  endtask

  task automatic test_dual_dispatch;
    br_payload_t pl2, pl3;
    data_t       v [4];
    pl2 = new_payload(5'b00100);
    pl3 = new_payload(5'b01000);
    foreach (v[k]) v[k] = $random(seed);
    @(posedge clk);
    load_port(1, 2'd2, pl2, v[0], v[1], 1'b1, 1'b0);
    load_port(2, 2'd3, pl3, v[2], v[3], 1'b1, 1'b0);
    idle_edge();
    wait_entry(3, 1'b0, 1'b1);
    check_vec(busyvec, 4'b1100, "busyvec after dual dispatch");
    show_entry(2'd2);
    check_payload(payload, pl2, "payload of entry 2");
    check_data(ex_src1, v[0], "ex_src1 of entry 2");
    check_data(ex_src2, v[1], "ex_src2 of entry 2");
    show_entry(2'd3);
    check_payload(payload, pl3, "payload of entry 3");
    check_data(ex_src1, v[2], "ex_src1 of entry 3");
    check_data(ex_src2, v[3], "ex_src2 of entry 3");
    clear_entry(2'd2);
    clear_entry(2'd3);
  endtask

  task automatic test_prmiss;
    spectag_t tags [4];
    spectag_t fix;
    ent_vec_t keep;
    tags = '{5'b00001, 5'b00010, 5'b00100, 5'b01000};
    fix  = 5'b00110;
    for (int i = 0; i < 4; i++) keep[i] = (tags[i] & fix) == '0;
    fill_entries(tags);
    @(posedge clk);
    specfixtag <= fix;
    issue_addr <= 2'd1;
    @(negedge clk);
    check_bit(specbit, 1'b1, "specbit before prmiss");
    check_vec(prbusyvec_next, keep, "prbusyvec_next");
    @(posedge clk);
    prmiss <= 1'b1;
    idle_edge();
    @(negedge clk);
    check_vec(busyvec, keep, "busyvec after prmiss");
    for (int i = 0; i < 4; i++) begin
      show_entry(ent_sel_t'(i));
      check_bit(specbit, 1'b0, "specbit after prmiss");
    end
    for (int i = 0; i < 4; i++) begin
      if (keep[i]) clear_entry(ent_sel_t'(i));
    end
  endtask

  task automatic test_prsuccess;
    spectag_t tags [4];
    tags = '{5'b00001, 5'b00010, 5'b00001, 5'b00100};
    fill_entries(tags);
    @(posedge clk);
    prtag      <= 5'b00001;
    prsuccess  <= 1'b1;
    issue_addr <= 2'd0;
    @(negedge clk);
    check_bit(specbit, 1'b0, "specbit during prsuccess");
    idle_edge();
    for (int i = 0; i < 4; i++) begin
      show_entry(ent_sel_t'(i));
      check_bit(specbit, tags[i] != 5'b00001, "specbit after prsuccess");
    end
    for (int i = 0; i < 4; i++) clear_entry(ent_sel_t'(i));
  endtask

  initial begin
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_vec(busyvec, 4'b0000, "busyvec after reset");
    check_vec(ready, 4'b0000, "ready after reset");
    test_single_issue();
    test_wakeup();
    test_dual_dispatch();
    test_prmiss();
    test_prsuccess();
    @(negedge clk);
    if (UUT.u_checker.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("Assertion checker flagged %0d failures", UUT.u_checker.fail_count);
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
rs_branch_pkg.sv
rs_slot_if.sv
rs_branch_slots.sv
rs_branch_tracker.sv
rs_branch_select.sv
rs_branch.sv
rs_branch_checker.sv
tb_rs_branch.sv
